// File: Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_frame_fifo
RTL_TOP    = frame_fifo_top
FILELIST   = build.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+hdl
hdl/frame_fifo_pkg.sv
hdl/axis_async_frame_fifo.sv
hdl/frame_stats_regs.sv
hdl/frame_fifo_top.sv
tb/frame_fifo_assert.sv
tb/tb_frame_fifo.sv

// File: hdl/axis_async_frame_fifo.sv
//////////////////////////////////////////////////
// dual-clock AXI4-Stream frame FIFO
// stores whole frames, releases a frame only on a
// good last beat, drops bad and oversized frames,
// reports each outcome as a pulse in both domains
//////////////////////////////////////////////////

`include "frame_fifo_defs.svh"

module axis_async_frame_fifo #(
    parameter int addr_width     = `FRAME_FIFO_ADDR_WIDTH,
    parameter bit drop_when_full = 1'b0
) (
    input  logic                          input_clk,
    input  logic                          output_clk,
    input  logic                          async_rst,
    input  frame_fifo_pkg::axis_beat_t    in_beat,
    input  logic                          in_valid,
    output logic                          in_ready,
    output frame_fifo_pkg::axis_beat_t    out_beat,
    output logic                          out_valid,
    input  logic                          out_ready,
    output frame_fifo_pkg::frame_status_t in_status,
    output frame_fifo_pkg::frame_status_t out_status
);

    localparam int depth = 2 ** addr_width;

    function automatic logic [addr_width:0] bin2gray(input logic [addr_width:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic logic [addr_width:0] gray2bin(input logic [addr_width:0] gray);
        logic [addr_width:0] bin;
        bin[addr_width] = gray[addr_width];
        for (int i = addr_width - 1; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    // reset synchronizers, one per domain
    logic [2:0] in_rst_pipe;
    logic [2:0] out_rst_pipe;
    logic       in_rst;
    logic       out_rst;
    logic       in_run;

    frame_fifo_pkg::axis_beat_t mem [depth];

    // write side
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] wr_ptr_next;
    logic [addr_width:0] wr_ptr_cur;
    logic [addr_width:0] wr_ptr_cur_next;
    logic [addr_width:0] wr_ptr_gray;
    logic [addr_width:0] rd_gray_sync1;
    logic [addr_width:0] rd_gray_sync2;
    logic [addr_width:0] rd_ptr_sync_bin;
    logic [addr_width:0] used_commit;
    logic [addr_width:0] used_cur;
    logic                full;
    logic                full_cur;
    logic                in_fire;
    logic                mem_we;
    logic                drop_frame;
    logic                drop_frame_next;
    logic [2:0]          status_tog;

    frame_fifo_pkg::frame_status_t status_next;

    // read side
    logic [addr_width:0] rd_ptr;
    logic [addr_width:0] rd_ptr_next;
    logic [addr_width:0] rd_ptr_gray;
    logic [addr_width:0] wr_gray_sync1;
    logic [addr_width:0] wr_gray_sync2;
    logic                empty;
    logic                mem_re;
    logic                out_valid_next;
    logic [2:0]          tog_sync1;
    logic [2:0]          tog_sync2;
    logic [2:0]          tog_last;

    // input side also waits for the output side to leave reset
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_pipe <= 3'b111;
        end else begin
            in_rst_pipe[0] <= 1'b0;
            in_rst_pipe[1] <= in_rst_pipe[0] | out_rst_pipe[0];
            in_rst_pipe[2] <= in_rst_pipe[1];
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_pipe <= 3'b111;
        end else begin
            out_rst_pipe <= {out_rst_pipe[1:0], 1'b0};
        end
    end

    assign in_rst  = in_rst_pipe[2];
    assign out_rst = out_rst_pipe[2];

    // occupancy seen from the write side, read pointer lags a few cycles
    assign rd_ptr_sync_bin = gray2bin(rd_gray_sync2);
    assign used_commit     = wr_ptr - rd_ptr_sync_bin;
    assign used_cur        = wr_ptr_cur - rd_ptr_sync_bin;
    assign full            = used_commit[addr_width];
    assign full_cur        = used_cur[addr_width];

    assign in_ready = (!full || drop_when_full) && in_run;
    assign in_fire  = in_valid && in_ready;

    // frame commit and rollback
    always_comb begin
        wr_ptr_next     = wr_ptr;
        wr_ptr_cur_next = wr_ptr_cur;
        drop_frame_next = drop_frame;
        mem_we          = 1'b0;
        status_next     = '0;
        if (in_fire) begin
            if (drop_frame || full_cur) begin
                // no room left for this frame, swallow the rest
                drop_frame_next = 1'b1;
                if (in_beat.tlast) begin
                    wr_ptr_cur_next      = wr_ptr;
                    drop_frame_next      = 1'b0;
                    status_next.overflow = 1'b1;
                end
            end else begin
                mem_we          = 1'b1;
                wr_ptr_cur_next = wr_ptr_cur + 1'b1;
                if (in_beat.tlast) begin
                    if (in_beat.tuser) begin
                        wr_ptr_cur_next       = wr_ptr;
                        status_next.bad_frame = 1'b1;
                    end else begin
                        wr_ptr_next            = wr_ptr_cur + 1'b1;
                        status_next.good_frame = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            in_run        <= 1'b0;
            wr_ptr        <= '0;
            wr_ptr_cur    <= '0;
            wr_ptr_gray   <= '0;
            drop_frame    <= 1'b0;
            in_status     <= '0;
            status_tog    <= '0;
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            in_run        <= 1'b1;
            wr_ptr        <= wr_ptr_next;
            wr_ptr_cur    <= wr_ptr_cur_next;
            wr_ptr_gray   <= bin2gray(wr_ptr_next);
            drop_frame    <= drop_frame_next;
            in_status     <= status_next;
            // each pulse flips its toggle for the output domain
            status_tog    <= status_tog ^ in_status;
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    always_ff @(posedge input_clk) begin
        if (mem_we) begin
            mem[wr_ptr_cur[addr_width-1:0]] <= '{
                tdata: in_beat.tdata,
                tkeep: in_beat.tkeep,
                tlast: in_beat.tlast,
                tuser: 1'b0
            };
        end
    end

    // only committed frames are visible here
    assign empty = (rd_ptr_gray == wr_gray_sync2);

    always_comb begin
        mem_re         = 1'b0;
        rd_ptr_next    = rd_ptr;
        out_valid_next = out_valid;
        if (out_ready || !out_valid) begin
            if (!empty) begin
                mem_re         = 1'b1;
                rd_ptr_next    = rd_ptr + 1'b1;
                out_valid_next = 1'b1;
            end else begin
                out_valid_next = 1'b0;
            end
        end
    end

    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            rd_ptr        <= '0;
            rd_ptr_gray   <= '0;
            out_valid     <= 1'b0;
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
            tog_sync1     <= '0;
            tog_sync2     <= '0;
            tog_last      <= '0;
        end else begin
            rd_ptr        <= rd_ptr_next;
            rd_ptr_gray   <= bin2gray(rd_ptr_next);
            out_valid     <= out_valid_next;
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
            tog_sync1     <= status_tog;
            tog_sync2     <= tog_sync1;
            tog_last      <= tog_sync2;
        end
    end

    // single output register
    always_ff @(posedge output_clk) begin
        if (mem_re) begin
            out_beat <= mem[rd_ptr[addr_width-1:0]];
        end
    end

    // edge of each synchronized toggle
    assign out_status = frame_fifo_pkg::frame_status_t'(tog_sync2 ^ tog_last);

endmodule

// File: hdl/frame_fifo_defs.svh
//////////////////////////////////////////////////
// frame FIFO shared sizes
// buffer depth, stream widths and statistics
// register sizes for the dual-clock frame FIFO
//////////////////////////////////////////////////

`ifndef FRAME_FIFO_DEFS_SVH
`define FRAME_FIFO_DEFS_SVH

// log2 of buffer depth in beats
`define FRAME_FIFO_ADDR_WIDTH 6

// stream payload
`define FRAME_FIFO_DATA_WIDTH 64
`define FRAME_FIFO_KEEP_WIDTH 8

// statistics counters and register offsets
`define FRAME_STATS_CNT_WIDTH 32
`define FRAME_STATS_ADDR_WIDTH 4

`endif

// File: hdl/frame_fifo_pkg.sv
//////////////////////////////////////////////////
// frame FIFO types
// stream beat, frame status, AXI4-Lite channel
// bundles and statistics register offsets
//////////////////////////////////////////////////

`include "frame_fifo_defs.svh"

package frame_fifo_pkg;

    // one stream beat, tuser only matters at the input
    typedef struct packed {
        logic [`FRAME_FIFO_DATA_WIDTH-1:0] tdata;
        logic [`FRAME_FIFO_KEEP_WIDTH-1:0] tkeep;
        logic                              tlast;
        logic                              tuser;
    } axis_beat_t;

    // frame outcome, one pulse per frame
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } frame_status_t;

    // shared by AW and AR
    typedef struct packed {
        logic [`FRAME_STATS_ADDR_WIDTH-1:0] addr;
        logic                               valid;
    } axil_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic        valid;
    } axil_wdata_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        valid;
    } axil_rdata_t;

    typedef enum logic [`FRAME_STATS_ADDR_WIDTH-1:0] {
        reg_good     = 4'h0,
        reg_bad      = 4'h4,
        reg_overflow = 4'h8,
        reg_clear    = 4'hC
    } stats_reg_e;

endpackage

// File: hdl/frame_fifo_top.sv
//////////////////////////////////////////////////
// frame FIFO subsystem top
// dual-clock frame FIFO plus the statistics
// block in the output domain
//////////////////////////////////////////////////

`include "frame_fifo_defs.svh"

module frame_fifo_top (
    input  logic                          input_clk,
    input  logic                          output_clk,
    input  logic                          async_rst,
    input  frame_fifo_pkg::axis_beat_t    in_beat,
    input  logic                          in_valid,
    output logic                          in_ready,
    output frame_fifo_pkg::axis_beat_t    out_beat,
    output logic                          out_valid,
    input  logic                          out_ready,
    output frame_fifo_pkg::frame_status_t in_status,
    input  frame_fifo_pkg::axil_addr_t    ar,
    output logic                          ar_ready,
    output frame_fifo_pkg::axil_rdata_t   r,
    input  logic                          r_ready,
    input  frame_fifo_pkg::axil_addr_t    aw,
    output logic                          aw_ready,
    input  frame_fifo_pkg::axil_wdata_t   w,
    output logic                          w_ready,
    output logic                          b_valid,
    input  logic                          b_ready
);

    // status pulses already moved into output_clk
    frame_fifo_pkg::frame_status_t out_status;

    axis_async_frame_fifo #(
        .addr_width     (`FRAME_FIFO_ADDR_WIDTH),
        .drop_when_full (1'b1)
    ) u_fifo (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .in_status  (in_status),
        .out_status (out_status)
    );

    frame_stats_regs u_stats (
        .output_clk   (output_clk),
        .async_rst    (async_rst),
        .frame_status (out_status),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r            (r),
        .r_ready      (r_ready),
        .aw           (aw),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_ready      (w_ready),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

endmodule

// File: hdl/frame_stats_regs.sv
//////////////////////////////////////////////////
// frame statistics registers
// counts good, bad and overflowed frames and
// serves the counts over an AXI4-Lite slave
//////////////////////////////////////////////////

`include "frame_fifo_defs.svh"

module frame_stats_regs (
    input  logic                          output_clk,
    input  logic                          async_rst,
    input  frame_fifo_pkg::frame_status_t frame_status,
    input  frame_fifo_pkg::axil_addr_t    ar,
    output logic                          ar_ready,
    output frame_fifo_pkg::axil_rdata_t   r,
    input  logic                          r_ready,
    input  frame_fifo_pkg::axil_addr_t    aw,
    output logic                          aw_ready,
    input  frame_fifo_pkg::axil_wdata_t   w,
    output logic                          w_ready,
    output logic                          b_valid,
    input  logic                          b_ready
);

    localparam int cnt_width = `FRAME_STATS_CNT_WIDTH;

    // index follows the status bit order: good, bad, overflow
    logic [cnt_width-1:0] cnt [3];
    logic [31:0]          rd_mux;
    logic [31:0]          rdata;
    logic                 r_valid;
    logic                 wr_accept;
    logic                 wr_fire;
    logic                 clear;

    always_comb begin
        case (frame_fifo_pkg::stats_reg_e'(ar.addr))
            frame_fifo_pkg::reg_good:     rd_mux = cnt[0];
            frame_fifo_pkg::reg_bad:      rd_mux = cnt[1];
            frame_fifo_pkg::reg_overflow: rd_mux = cnt[2];
            default:                      rd_mux = '0;
        endcase
    end

    // write data carries nothing, the offset alone selects the clear
    assign wr_fire = wr_accept && aw.valid && w.valid;
    assign clear   = wr_fire && (aw.addr == frame_fifo_pkg::reg_clear);

    // clear wins over a same-cycle count
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (frame_status[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // read channel, one response outstanding at most
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else if (ar_ready && ar.valid) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
        end else if (r_valid && r_ready) begin
            r_valid  <= 1'b0;
            ar_ready <= 1'b1;
        end else if (!r_valid) begin
            ar_ready <= 1'b1;
        end
    end

    always_ff @(posedge output_clk) begin
        if (ar_ready && ar.valid) begin
            rdata <= rd_mux;
        end
    end

    assign r = '{data: rdata, resp: 2'b00, valid: r_valid};

    // write channel, AW and W accepted together for one cycle
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            wr_accept <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            wr_accept <= aw.valid && w.valid && !b_valid && !wr_accept;
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    assign aw_ready = wr_accept;
    assign w_ready  = wr_accept;

endmodule

// File: tb/frame_fifo_assert.sv
//////////////////////////////////////////////////
// frame FIFO protocol checks
// stream and AXI4-Lite handshake stability, and
// quiet outputs during and right after reset
//////////////////////////////////////////////////

module frame_fifo_assert (
    input logic                          input_clk,
    input logic                          output_clk,
    input logic                          async_rst,
    input logic                          in_ready,
    input frame_fifo_pkg::frame_status_t in_status,
    input frame_fifo_pkg::axis_beat_t    out_beat,
    input logic                          out_valid,
    input logic                          out_ready,
    input frame_fifo_pkg::frame_status_t out_status,
    input frame_fifo_pkg::axil_rdata_t   r,
    input logic                          r_ready,
    input logic                          b_valid,
    input logic                          b_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // failures per clock domain
    int unsigned in_fails = 0;
    int unsigned out_fails = 0;

    // stalled output beat holds
    a_out_hold: assert property (@(posedge output_clk) disable iff (async_rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
        out_fails++;
        $error("out_beat or out_valid changed while out_ready was low");
    end

    a_r_hold: assert property (@(posedge output_clk) disable iff (async_rst)
        r.valid && !r_ready |=> r.valid && $stable(r.data))
    else begin
        out_fails++;
        $error("read response dropped before r_ready");
    end

    a_b_hold: assert property (@(posedge output_clk) disable iff (async_rst)
        b_valid && !b_ready |=> b_valid)
    else begin
        out_fails++;
        $error("write response dropped before b_ready");
    end

    // reset plus three cycles
    a_in_quiet: assert property (@(posedge input_clk)
        (async_rst || $past(async_rst) || $past(async_rst, 2) || $past(async_rst, 3))
        |-> !in_ready && in_status == '0)
    else begin
        in_fails++;
        $error("input side active too early around reset");
    end

    // response valids only checked while reset is held
    a_out_quiet: assert property (@(posedge output_clk)
        (async_rst || $past(async_rst) || $past(async_rst, 2) || $past(async_rst, 3))
        |-> !out_valid && out_status == '0 && (!async_rst || (!r.valid && !b_valid)))
    else begin
        out_fails++;
        $error("output side active too early around reset");
    end

endmodule

// File: tb/tb_frame_fifo.sv
//////////////////////////////////////////////////
// frame FIFO subsystem testbench
// random good and bad frames, one oversized frame,
// stream scoreboard and statistics register reads
//////////////////////////////////////////////////

`include "frame_fifo_defs.svh"

module tb_frame_fifo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth      = 1 << `FRAME_FIFO_ADDR_WIDTH;
    localparam int num_frames = 24;
    localparam int max_len    = 16;
    localparam int over_len   = depth + 6;
    localparam int over_frame = 9;
    localparam int timeout_ns = num_frames * max_len * 6 * 8 + 16 * 4;

    logic                          input_clk = 1'b0;
    logic                          output_clk = 1'b0;
    logic                          async_rst;
    frame_fifo_pkg::axis_beat_t    in_beat;
    logic                          in_valid;
    logic                          in_ready;
    frame_fifo_pkg::axis_beat_t    out_beat;
    logic                          out_valid;
    logic                          out_ready = 1'b0;
    frame_fifo_pkg::frame_status_t in_status;
    frame_fifo_pkg::axil_addr_t    ar;
    logic                          ar_ready;
    frame_fifo_pkg::axil_rdata_t   r;
    logic                          r_ready;
    frame_fifo_pkg::axil_addr_t    aw;
    logic                          aw_ready;
    frame_fifo_pkg::axil_wdata_t   w;
    logic                          w_ready;
    logic                          b_valid;
    logic                          b_ready;

    // expected beats of committed frames in send order
    frame_fifo_pkg::axis_beat_t expected [$];
    frame_fifo_pkg::axis_beat_t exp_beat;

    int unsigned data_seed = 30;
    int unsigned ready_seed = 30;
    int unsigned beat_errors = 0;
    int unsigned main_errors = 0;
    int unsigned good_pulses = 0;
    int unsigned bad_pulses = 0;
    int unsigned over_pulses = 0;

    frame_fifo_top dut (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .in_status  (in_status),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_ready    (r_ready),
        .aw         (aw),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

    bind frame_fifo_top frame_fifo_assert u_checks (
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .async_rst  (async_rst),
        .in_ready   (in_ready),
        .in_status  (in_status),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_status (out_status),
        .r          (r),
        .r_ready    (r_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

    always #2 input_clk = ~input_clk;
    always #3 output_clk = ~output_clk;

    function automatic int unsigned lcg_step(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // returns 1 on a mismatch
    function automatic int check_value(input string name, input logic [63:0] want,
                                       input logic [63:0] got);
        int failed;
        failed = 0;
        assert (want === got) else begin
            $display("Fail %s expected %0h actual %0h", name, want, got);
            failed = 1;
        end
        return failed;
    endfunction

    task automatic send_frame(input int len, input bit bad);
        frame_fifo_pkg::axis_beat_t beat;
        for (int i = 0; i < len; i++) begin
            data_seed  = lcg_step(data_seed);
            beat.tdata = {data_seed, lcg_step(data_seed)};
            data_seed  = lcg_step(lcg_step(data_seed));
            beat.tkeep = '1;
            if (i == len - 1) begin
                beat.tkeep    = data_seed[`FRAME_FIFO_KEEP_WIDTH-1:0];
                beat.tkeep[0] = 1'b1;
            end
            beat.tlast = (i == len - 1);
            beat.tuser = bad && (i == len - 1);
            @(negedge input_clk);
            in_beat  = beat;
            in_valid = 1'b1;
            do begin
                @(posedge input_clk);
            end while (!in_ready);
            // oversized and bad frames never reach the output
            if (!bad && len <= depth) begin
                expected.push_back(beat);
            end
        end
        @(negedge input_clk);
        in_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        @(negedge output_clk);
        ar = '{addr: addr, valid: 1'b1};
        do begin
            @(posedge output_clk);
        end while (!ar_ready);
        @(negedge output_clk);
        ar.valid = 1'b0;
        // r_ready one cycle late so the response has to wait
        @(negedge output_clk);
        r_ready = 1'b1;
        do begin
            @(posedge output_clk);
        end while (!r.valid);
        data = r.data;
        // responses are always OKAY
        main_errors += check_value("read resp", 64'(0), 64'(r.resp));
        @(negedge output_clk);
        r_ready = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr);
        @(negedge output_clk);
        aw = '{addr: addr, valid: 1'b1};
        w  = '{data: '0, valid: 1'b1};
        do begin
            @(posedge output_clk);
        end while (!aw_ready);
        // AW and W are taken in the same cycle
        main_errors += check_value("w_ready", 64'(1), 64'(w_ready));
        @(negedge output_clk);
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        @(negedge output_clk);
        b_ready = 1'b1;
        do begin
            @(posedge output_clk);
        end while (!b_valid);
        @(negedge output_clk);
        b_ready = 1'b0;
    endtask

    task automatic expect_count(input string name, input logic [3:0] addr,
                                input int unsigned want);
        logic [31:0] data;
        int          tries;
        tries = 0;
        read_reg(addr, data);
        // counters trail the input side by a few output cycles
        while (data != want && tries < 16) begin
            read_reg(addr, data);
            tries++;
        end
        main_errors += check_value(name, 64'(want), 64'(data));
    endtask

    always @(negedge output_clk) begin
        ready_seed = lcg_step(ready_seed);
        out_ready  = ready_seed[30:29] != 2'b00;
    end

    // stream scoreboard
    always @(posedge output_clk) begin
        if (out_valid && out_ready) begin
            if (expected.size() == 0) begin
                beat_errors++;
                $display("output beat arrived while no good frame was pending");
            end else begin
                exp_beat = expected.pop_front();
                beat_errors += check_value("tdata", exp_beat.tdata, out_beat.tdata);
                beat_errors += check_value("tkeep", 64'(exp_beat.tkeep), 64'(out_beat.tkeep));
                beat_errors += check_value("tlast", 64'(exp_beat.tlast), 64'(out_beat.tlast));
            end
        end
    end

    always @(posedge input_clk) begin
        if (in_status.good_frame) begin
            good_pulses++;
        end
        if (in_status.bad_frame) begin
            bad_pulses++;
        end
        if (in_status.overflow) begin
            over_pulses++;
        end
    end

    initial begin
        int          len;
        bit          bad;
        int unsigned n_good;
        int unsigned n_bad;
        int unsigned n_over;
        int unsigned assert_fails;
        n_good    = 0;
        n_bad     = 0;
        n_over    = 0;
        in_beat   = '0;
        in_valid  = 1'b0;
        ar        = '0;
        aw        = '0;
        w         = '0;
        r_ready   = 1'b0;
        b_ready   = 1'b0;
        async_rst = 1'b1;
        repeat (16) @(negedge input_clk);
        async_rst = 1'b0;

        for (int f = 0; f < num_frames; f++) begin
            while (expected.size() != 0) begin
                @(posedge input_clk);
            end
            if (f == over_frame) begin
                send_frame(over_len, 1'b0);
                n_over++;
            end else begin
                data_seed = lcg_step(data_seed);
                len       = int'(data_seed % max_len) + 1;
                bad       = data_seed[27:26] == 2'b00;
                send_frame(len, bad);
                if (bad) begin
                    n_bad++;
                end else begin
                    n_good++;
                end
            end
        end
        while (expected.size() != 0) begin
            @(posedge input_clk);
        end
        // status pulse follows the last beat by one cycle
        repeat (2) @(negedge input_clk);
        main_errors += check_value("good pulses", 64'(n_good), 64'(good_pulses));
        main_errors += check_value("bad pulses", 64'(n_bad), 64'(bad_pulses));
        main_errors += check_value("overflow pulses", 64'(n_over), 64'(over_pulses));

        expect_count("good count", frame_fifo_pkg::reg_good, n_good);
        expect_count("bad count", frame_fifo_pkg::reg_bad, n_bad);
        expect_count("overflow count", frame_fifo_pkg::reg_overflow, n_over);
        write_reg(frame_fifo_pkg::reg_clear);
        expect_count("good after clear", frame_fifo_pkg::reg_good, 0);
        expect_count("bad after clear", frame_fifo_pkg::reg_bad, 0);
        expect_count("overflow after clear", frame_fifo_pkg::reg_overflow, 0);

        assert_fails = dut.u_checks.in_fails + dut.u_checks.out_fails;
        $display("beat errors %0d, check errors %0d, assertion failures %0d",
                 beat_errors, main_errors, assert_fails);
        if (beat_errors == 0 && main_errors == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns);
        $display("timeout after %0d ns with %0d beats still expected",
                 timeout_ns, expected.size());
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
